/* tb.f */
+incdir+common
common/cpu_pkg.sv
ctl_unit/ctl_unit.sv
hdl/ins_dec.sv
hdl/reg_file.sv
hdl/ins_exec.sv
hdl/cpu_core.sv
verification/tb_clock.sv
verification/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f tb.f --Mdir "$BUILD_DIR" -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "TEST FAILED" "$LOG_FILE"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0

/* verification/tb_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_top;

    import cpu_pkg::*;

    localparam int PROG_LEN       = 60;
    localparam int MEM_WORDS      = 512;
    localparam int DATA_BASE      = 32'h400;
    localparam int DATA_WORDS     = 64;
    localparam int STROBE_TIMEOUT = 40;
    localparam int MAX_INS        = 400;
    localparam logic [31:0] HALT_PC = 32'((PROG_LEN - 1) * 4);

    localparam logic [6:0] RV_LUI    = 7'h37;
    localparam logic [6:0] RV_JAL    = 7'h6f;
    localparam logic [6:0] RV_JALR   = 7'h67;
    localparam logic [6:0] RV_BRANCH = 7'h63;
    localparam logic [6:0] RV_LOAD   = 7'h03;
    localparam logic [6:0] RV_STORE  = 7'h23;
    localparam logic [6:0] RV_OP_IMM = 7'h13;
    localparam logic [6:0] RV_OP     = 7'h33;

    logic                   sys_clk;
    logic                   sys_rst;
    mem_req_t               mem_req;
    logic [`CPU_XLEN-1:0]   mem_rdata = '0;

    logic [31:0]    model_mem [MEM_WORDS];
    logic [31:0]    iss_mem [MEM_WORDS];
    logic [31:0]    iss_regs [32];
    logic [31:0]    iss_pc;
    logic           rd_pending = 1'b0;
    logic [31:0]    rd_addr = '0;
    integer         seed;

    tb_clock #(.PERIOD_NS(40)) u_clock (.sys_clk(sys_clk));

    cpu_core cpu_core_inst (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .mem_req(mem_req), .mem_rdata(mem_rdata)
    );

    // ========================================
    // reporting
    // ========================================

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s, got %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic wait_strobe(output mem_req_t req);
        int n;
        n = 0;
        while (!mem_req.op) begin
            if (n == STROBE_TIMEOUT) begin
                fail_run("no memory request from the core within the timeout");
            end
            @(negedge sys_clk);
            n++;
        end
        req = mem_req;
        // step past this strobe
        @(negedge sys_clk);
    endtask

    // ========================================
    // instruction encoding and program
    // ========================================

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, RV_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], RV_STORE};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], RV_BRANCH};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, RV_LUI};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, RV_JAL};
    endfunction

    function automatic logic [2:0] pick_funct3(input int k);
        case (k)
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b100;
            3:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[31:2]);
    endfunction

    task automatic rand_below(input int n, output int v);
        v = int'($unsigned($random(seed)) % n);
    endtask

    task automatic build_program();
        int             kind;
        int             rd;
        int             rs1;
        int             rs2;
        int             f;
        logic [31:0]    raw;
        logic [31:0]    w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = (32'(i * 4) * 32'h9e37_79b9) ^ 32'h6c07_8965;
        end
        // x31 holds the data region base
        model_mem[0] = encode_i(12'(DATA_BASE), 5'd0, 3'b000, 5'd31, RV_OP_IMM);
        for (int i = 1; i < PROG_LEN - 1; i++) begin
            raw = $random(seed);
            rand_below(15, rd);
            rand_below(16, rs1);
            rand_below(16, rs2);
            rand_below(8, kind);
            rand_below(6, f);
            if (i == 20) begin
                w = {raw[31:7], 7'b0001011};
            end else if (i == 30) begin
                w = encode_j(21'd12, 5'(rd + 1));
            end else if (i == 45) begin
                w = encode_i(12'((i + 2) * 4), 5'd0, 3'b000, 5'(rd + 1), RV_JALR);
            end else begin
                case (kind)
                    0: w = encode_u(raw[31:12], 5'(rd + 1));
                    2: w = encode_i(raw[11:0], 5'(rs1), pick_funct3(f), 5'(rd + 1), RV_OP_IMM);
                    3, 7: w = (f == 5) ? encode_r(7'b0100000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd + 1))
                                       : encode_r(7'b0, 5'(rs2), 5'(rs1), pick_funct3(f),
                                                  5'(rd + 1));
                    4: w = encode_s({4'b0, raw[7:2], 2'b00}, 5'(rs2), 5'd31);
                    5: w = encode_i({4'b0, raw[7:2], 2'b00}, 5'd31, 3'b010, 5'(rd + 1), RV_LOAD);
                    6: w = (i <= PROG_LEN - 3)
                           ? encode_b(13'd8, raw[8] ? 5'(rs1) : 5'(rs2), 5'(rs1), {2'b00, raw[9]})
                           : encode_i(raw[11:0], 5'(rs1), 3'b000, 5'(rd + 1), RV_OP_IMM);
                    default: w = encode_i(raw[11:0], 5'(rs1), 3'b000, 5'(rd + 1), RV_OP_IMM);
                endcase
            end
            model_mem[i] = w;
        end
        model_mem[PROG_LEN - 1] = encode_j(21'd0, 5'd0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            iss_mem[i] = model_mem[i];
        end
    endtask

    // ========================================
    // reference model
    // ========================================

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic iss_step(output logic is_load, output logic is_store,
                            output logic [31:0] addr, output logic [31:0] data);
        logic [31:0]    ins;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    imm_i;
        logic [31:0]    next_pc;
        logic [31:0]    result;
        logic           wb;
        ins     = iss_mem[word_index(iss_pc)];
        a       = iss_regs[ins[19:15]];
        b       = iss_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = iss_pc + 32'd4;
        result  = '0;
        wb      = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        addr     = a + imm_i;
        data     = b;
        case (ins[6:0])
            RV_LUI: begin
                result = {ins[31:12], 12'b0};
                wb     = 1'b1;
            end
            RV_JAL: begin
                result  = iss_pc + 32'd4;
                next_pc = iss_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                wb      = 1'b1;
            end
            RV_JALR: begin
                result  = iss_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
                wb      = 1'b1;
            end
            RV_BRANCH: begin
                if ((a == b) != ins[12]) begin
                    next_pc = iss_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            RV_LOAD: begin
                is_load = 1'b1;
                result  = iss_mem[word_index(addr)];
                wb      = 1'b1;
            end
            RV_STORE: begin
                is_store = 1'b1;
                addr     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                iss_mem[word_index(addr)] = b;
            end
            RV_OP_IMM: begin
                result = alu_model(ins[14:12], 1'b0, a, imm_i);
                wb     = 1'b1;
            end
            RV_OP: begin
                result = alu_model(ins[14:12], ins[30], a, b);
                wb     = 1'b1;
            end
            default: begin
            end
        endcase
        if (wb && ins[11:7] != 5'd0) begin
            iss_regs[ins[11:7]] = result;
        end
        iss_pc = next_pc;
    endtask

    // ========================================
    // memory model
    // ========================================

    // read data shows up one cycle after the request
    always @(negedge sys_clk) begin
        if (rd_pending) begin
            mem_rdata = model_mem[word_index(rd_addr)];
        end
        rd_pending = 1'b0;
        if (mem_req.op) begin
            if (mem_req.addr >= 32'(MEM_WORDS * 4) || mem_req.addr[1:0] != 2'b00) begin
                fail_run("memory request to an address outside the model memory");
            end
            if (mem_req.rw) begin
                model_mem[word_index(mem_req.addr)] = mem_req.wdata;
            end else begin
                rd_pending = 1'b1;
                rd_addr    = mem_req.addr;
            end
        end
    end

    // ========================================
    // stimulus and checking
    // ========================================

    initial begin
        mem_req_t       req;
        logic           is_load;
        logic           is_store;
        logic [31:0]    addr;
        logic [31:0]    data;
        logic           halted;
        sys_rst = 1'b1;
        seed    = 32'h48ec_fac3;
        halted  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            iss_regs[i] = '0;
        end
        build_program();
        iss_pc = `CPU_RESET_PC;

        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;

        for (int n = 0; n < MAX_INS && !halted; n++) begin
            wait_strobe(req);
            check_equal(32'(req.rw), 32'd0, "fetch strobe must be a read");
            check_equal(req.addr, iss_pc, "fetch address");
            if (iss_pc == HALT_PC) begin
                halted = 1'b1;
            end else begin
                iss_step(is_load, is_store, addr, data);
                if (is_load) begin
                    wait_strobe(req);
                    check_equal(32'(req.rw), 32'd0, "load strobe must be a read");
                    check_equal(req.addr, addr, "load address");
                end
                if (is_store) begin
                    wait_strobe(req);
                    check_equal(32'(req.rw), 32'd1, "store strobe must be a write");
                    check_equal(req.addr, addr, "store address");
                    check_equal(req.wdata, data, "store data");
                end
            end
        end

        if (!halted) begin
            fail_run("the program never reached the halt instruction");
        end else begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                check_equal(model_mem[DATA_BASE / 4 + i], iss_mem[DATA_BASE / 4 + i],
                            $sformatf("data word %0d", i));
            end
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic sys_clk
);

    initial begin
        sys_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) sys_clk = ~sys_clk;

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core (
    input  logic                    sys_clk,
    input  logic                    sys_rst,
    output cpu_pkg::mem_req_t       mem_req,
    input  logic [`CPU_XLEN-1:0]    mem_rdata
);

    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0]       ins;
    dec_ins_t                   dec;
    exec_res_t                  res;

    logic [`CPU_REG_IDX_W-1:0]  rf_rd_idx_a;
    logic [`CPU_REG_IDX_W-1:0]  rf_rd_idx_b;
    logic [`CPU_XLEN-1:0]       rf_rd_val_a;
    logic [`CPU_XLEN-1:0]       rf_rd_val_b;
    logic                       rf_we;
    logic [`CPU_REG_IDX_W-1:0]  rf_w_idx;
    logic [`CPU_XLEN-1:0]       rf_w_val;

    logic [`CPU_XLEN-1:0]       pc;
    logic [`CPU_XLEN-1:0]       rs1_val;
    logic [`CPU_XLEN-1:0]       rs2_val;
    logic [`CPU_XLEN-1:0]       load_val;

    ctl_unit u_ctl_unit (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .mem_req(mem_req), .mem_rdata(mem_rdata),
        .ins(ins), .dec(dec),
        .rf_rd_idx_a(rf_rd_idx_a), .rf_rd_idx_b(rf_rd_idx_b),
        .rf_rd_val_a(rf_rd_val_a), .rf_rd_val_b(rf_rd_val_b),
        .rf_we(rf_we), .rf_w_idx(rf_w_idx), .rf_w_val(rf_w_val),
        .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val), .load_val(load_val),
        .res(res)
    );

    ins_dec u_ins_dec (.ins(ins), .dec(dec));

    reg_file u_reg_file (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .rd_idx_a(rf_rd_idx_a), .rd_idx_b(rf_rd_idx_b),
        .rd_val_a(rf_rd_val_a), .rd_val_b(rf_rd_val_b),
        .we(rf_we), .w_idx(rf_w_idx), .w_val(rf_w_val)
    );

    ins_exec u_ins_exec (
        .dec(dec), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .load_val(load_val), .res(res)
    );

endmodule

/* hdl/ins_exec.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module ins_exec (
    input  cpu_pkg::dec_ins_t       dec,
    input  logic [`CPU_XLEN-1:0]    pc,
    input  logic [`CPU_XLEN-1:0]    rs1_val,
    input  logic [`CPU_XLEN-1:0]    rs2_val,
    input  logic [`CPU_XLEN-1:0]    load_val,
    output cpu_pkg::exec_res_t      res
);

    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0]   opnd_b;
    logic [`CPU_XLEN-1:0]   alu_y;
    logic [`CPU_XLEN-1:0]   addr_sum;
    logic [`CPU_XLEN-1:0]   link;
    logic                   lt;
    logic                   eq;
    logic                   taken;

    // ======================================
    // alu
    // ======================================

    assign opnd_b = (dec.opcode == OPC_OP) ? rs2_val : dec.imm;
    assign lt     = $signed(rs1_val) < $signed(opnd_b);

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_y = rs1_val + opnd_b;
            ALU_SUB:    alu_y = rs1_val - opnd_b;
            ALU_XOR:    alu_y = rs1_val ^ opnd_b;
            ALU_OR:     alu_y = rs1_val | opnd_b;
            ALU_AND:    alu_y = rs1_val & opnd_b;
            ALU_SLT:    alu_y = {{(`CPU_XLEN-1){1'b0}}, lt};
            ALU_PASS_B: alu_y = opnd_b;
            default:    alu_y = rs1_val + opnd_b;
        endcase
    end

    // ======================================
    // address, link and branch
    // ======================================

    // shared by loads, stores and jalr
    assign addr_sum = rs1_val + dec.imm;
    assign link     = pc + `CPU_INS_BYTES;
    assign eq       = (rs1_val == rs2_val);
    assign taken    = dec.is_branch_ne ? !eq : eq;

    always_comb begin
        res            = '0;
        res.reg_w_op   = dec.writes_rd;
        res.reg_w_idx  = dec.rd;
        res.mem_w_op   = dec.is_store;
        res.mem_w_addr = addr_sum;
        res.mem_w_val  = rs2_val;
        res.pc_w_val   = pc + dec.imm;

        case (dec.opcode)
            OPC_LOAD: begin
                res.reg_w_val = load_val;
            end
            OPC_JAL: begin
                res.reg_w_val = link;
                res.pc_w_op   = 1'b1;
            end
            OPC_JALR: begin
                res.reg_w_val = link;
                res.pc_w_op   = 1'b1;
                res.pc_w_val  = {addr_sum[`CPU_XLEN-1:1], 1'b0};
            end
            OPC_BRANCH: begin
                res.reg_w_val = alu_y;
                res.pc_w_op   = taken;
            end
            default: begin
                // unknown opcodes fall through to pc + 4
                res.reg_w_val = alu_y;
            end
        endcase
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
    input  logic                        sys_clk,
    input  logic                        sys_rst,
    input  logic [`CPU_REG_IDX_W-1:0]   rd_idx_a,
    input  logic [`CPU_REG_IDX_W-1:0]   rd_idx_b,
    output logic [`CPU_XLEN-1:0]        rd_val_a,
    output logic [`CPU_XLEN-1:0]        rd_val_b,
    input  logic                        we,
    input  logic [`CPU_REG_IDX_W-1:0]   w_idx,
    input  logic [`CPU_XLEN-1:0]        w_val
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && w_idx != '0) begin
            regs[w_idx] <= w_val;
        end
    end

    // x0 is cleared by reset and never written
    assign rd_val_a = regs[rd_idx_a];
    assign rd_val_b = regs[rd_idx_b];

    a_x0_zero: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (we && w_idx == '0) |=> (rd_idx_a != '0 || rd_val_a == '0));

endmodule

/* hdl/ins_dec.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module ins_dec (
    input  logic [`CPU_XLEN-1:0]    ins,
    output cpu_pkg::dec_ins_t       dec
);

    import cpu_pkg::*;

    logic [2:0]     funct3;
    logic [6:0]     funct7;
    opcode_t        opcode;

    assign opcode = opcode_t'(ins[6:0]);
    assign funct3 = ins[14:12];
    assign funct7 = ins[31:25];

    always_comb begin
        dec        = '0;
        dec.opcode = opcode;
        dec.rd     = ins[11:7];
        dec.rs1    = ins[19:15];
        dec.rs2    = ins[24:20];
        dec.alu_op = ALU_ADD;

        case (opcode)
            OPC_LUI: begin
                dec.imm       = {ins[31:12], 12'b0};
                dec.alu_op    = ALU_PASS_B;
                dec.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                dec.imm       = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                dec.writes_rd = 1'b1;
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                dec.imm       = {{20{ins[31]}}, ins[31:20]};
                dec.is_load   = (opcode == OPC_LOAD);
                dec.writes_rd = 1'b1;
            end
            OPC_STORE: begin
                dec.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                dec.is_store  = 1'b1;
                dec.reads_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm          = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                dec.is_branch_ne = funct3[0];
                dec.reads_rs2    = 1'b1;
            end
            OPC_OP: begin
                dec.reads_rs2 = 1'b1;
                dec.writes_rd = 1'b1;
            end
            default: begin
                // unknown opcode, no side effects
                dec.writes_rd = 1'b0;
            end
        endcase

        // alu function for register and immediate arithmetic
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000:  dec.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b010:  dec.alu_op = ALU_SLT;
                3'b100:  dec.alu_op = ALU_XOR;
                3'b110:  dec.alu_op = ALU_OR;
                3'b111:  dec.alu_op = ALU_AND;
                default: dec.alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

/* ctl_unit/ctl_unit.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module ctl_unit (
    input  logic                        sys_clk,
    input  logic                        sys_rst,

    output cpu_pkg::mem_req_t           mem_req,
    input  logic [`CPU_XLEN-1:0]        mem_rdata,

    output logic [`CPU_XLEN-1:0]        ins,
    input  cpu_pkg::dec_ins_t           dec,

    output logic [`CPU_REG_IDX_W-1:0]   rf_rd_idx_a,
    output logic [`CPU_REG_IDX_W-1:0]   rf_rd_idx_b,
    input  logic [`CPU_XLEN-1:0]        rf_rd_val_a,
    input  logic [`CPU_XLEN-1:0]        rf_rd_val_b,

    output logic                        rf_we,
    output logic [`CPU_REG_IDX_W-1:0]   rf_w_idx,
    output logic [`CPU_XLEN-1:0]        rf_w_val,

    output logic [`CPU_XLEN-1:0]        pc,
    output logic [`CPU_XLEN-1:0]        rs1_val,
    output logic [`CPU_XLEN-1:0]        rs2_val,
    output logic [`CPU_XLEN-1:0]        load_val,

    input  cpu_pkg::exec_res_t          res
);

    import cpu_pkg::*;

    cpu_state_t     state;
    cpu_state_t     state_next;
    exec_res_t      res_q;

    // ======================================
    // phase sequencer
    // ======================================

    always_comb begin
        case (state)
            ST_FETCH:      state_next = ST_FETCH_WAIT;
            ST_FETCH_WAIT: state_next = ST_DEC;
            ST_DEC:        state_next = ST_REG_R;
            // only loads go through the memory read phase
            ST_REG_R:      state_next = dec.is_load ? ST_MEM_R : ST_EXEC;
            ST_MEM_R:      state_next = ST_MEM_R_WAIT;
            ST_MEM_R_WAIT: state_next = ST_EXEC;
            ST_EXEC:       state_next = ST_REG_W;
            ST_REG_W:      state_next = ST_MEM_W;
            ST_MEM_W:      state_next = ST_PC_NEXT;
            ST_PC_NEXT:    state_next = ST_FETCH;
            default:       state_next = ST_FETCH;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state <= ST_FETCH;
            pc    <= `CPU_RESET_PC;
        end else begin
            state <= state_next;
            if (state == ST_PC_NEXT) begin
                pc <= res_q.pc_w_op ? res_q.pc_w_val : pc + `CPU_INS_BYTES;
            end
        end
    end

    // latched instruction, operands and result
    always_ff @(posedge sys_clk) begin
        if (state == ST_FETCH_WAIT) begin
            ins <= mem_rdata;
        end
        if (state == ST_REG_R) begin
            rs1_val <= rf_rd_val_a;
            rs2_val <= rf_rd_val_b;
        end
        if (state == ST_MEM_R_WAIT) begin
            load_val <= mem_rdata;
        end
        if (state == ST_EXEC) begin
            res_q <= res;
        end
    end

    // ======================================
    // register file and memory ports
    // ======================================

    assign rf_rd_idx_a = dec.rs1;
    // unused second operand reads as x0
    assign rf_rd_idx_b = dec.reads_rs2 ? dec.rs2 : '0;

    assign rf_we    = (state == ST_REG_W) && res_q.reg_w_op;
    assign rf_w_idx = res_q.reg_w_idx;
    assign rf_w_val = res_q.reg_w_val;

    always_comb begin
        mem_req = '0;
        case (state)
            ST_FETCH: begin
                mem_req.op   = 1'b1;
                mem_req.addr = pc;
            end
            ST_MEM_R: begin
                // address comes straight from the executor adder
                mem_req.op   = 1'b1;
                mem_req.addr = res.mem_w_addr;
            end
            ST_MEM_W: begin
                mem_req.op    = res_q.mem_w_op;
                mem_req.rw    = 1'b1;
                mem_req.addr  = res_q.mem_w_addr;
                mem_req.wdata = res_q.mem_w_val;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // writes only in the memory write phase of a store
    a_mem_w_phase: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (mem_req.op && mem_req.rw) |-> (state == ST_MEM_W && dec.is_store));

    a_fetch_align: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (state == ST_FETCH) |-> (mem_req.addr[1:0] == 2'b00));

endmodule

/* common/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    // ======================================
    // enums
    // ======================================

    typedef enum logic [3:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_DEC,
        ST_REG_R,
        ST_MEM_R,
        ST_MEM_R_WAIT,
        ST_EXEC,
        ST_REG_W,
        ST_MEM_W,
        ST_PC_NEXT
    } cpu_state_t;

    // rv32i major opcodes still supported
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // ======================================
    // bundles
    // ======================================

    // rw set means write
    typedef struct packed {
        logic                   op;
        logic                   rw;
        logic [`CPU_XLEN-1:0]   addr;
        logic [`CPU_XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        opcode_t                opcode;
        alu_op_t                alu_op;
        logic [`CPU_REG_IDX_W-1:0] rs1;
        logic [`CPU_REG_IDX_W-1:0] rs2;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [`CPU_XLEN-1:0]   imm;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch_ne;
        logic                   reads_rs2;
        logic                   writes_rd;
    } dec_ins_t;

    typedef struct packed {
        logic                   reg_w_op;
        logic [`CPU_REG_IDX_W-1:0] reg_w_idx;
        logic [`CPU_XLEN-1:0]   reg_w_val;
        logic                   mem_w_op;
        logic [`CPU_XLEN-1:0]   mem_w_addr;
        logic [`CPU_XLEN-1:0]   mem_w_val;
        logic                   pc_w_op;
        logic [`CPU_XLEN-1:0]   pc_w_val;
    } exec_res_t;

endpackage

/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define CPU_XLEN        32

// register file geometry
`define CPU_REG_COUNT   32
`define CPU_REG_IDX_W   5

// first fetch address and step per instruction
`define CPU_RESET_PC    32'h0000_0000
`define CPU_INS_BYTES   32'd4

`endif
